/* filelist.f */
+incdir+design
design/draw_pkg.sv
design/rnd_gen.sv
design/pattern_sequencer.sv
design/pixel_addr_pipe.sv
design/write_cache.sv
design/pattern_draw_top.sv
sim/tb_pattern_draw_properties.sv
sim/tb_pattern_draw.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pattern_draw
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) design/draw_macros.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Regression passed" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_pattern_draw.sv */
`timescale 1ns/1ns
`include "draw_macros.svh"

module tb_pattern_draw;

    import draw_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int SAMPLE_DLY = 10;  // Port settled after the falling edge
    localparam int IDLE_WIN   = 80;  // Quiet cycles that close a row
    localparam int NUM_ROWS   = 7;

    typedef struct packed {
        logic [1:0]  buttons;      // Active low
        logic [2:0]  pixel_bytes;
        logic [31:0] mem_addr;
        logic [15:0] width;
        logic [15:0] height;
        logic [6:0]  busy_pct;     // Share of cycles with write_busy high
    } stim_row_t;

    // *************************************************************************
    // Stimulus table
    // *************************************************************************
    localparam stim_row_t ROWS [NUM_ROWS] = '{
        '{2'b01, 3'd4, 32'h0010_0000, 16'd16, 16'd12, 7'd0},   // Counter fill with 32 bit pixels
        '{2'b01, 3'd1, 32'h0000_0123, 16'd10, 16'd5,  7'd0},   // 8 bit pixels
        '{2'b01, 3'd2, 32'h0004_0002, 16'd7,  16'd9,  7'd0},   // 16 bit pixels
        '{2'b01, 3'd4, 32'h0010_0000, 16'd16, 16'd12, 7'd60},  // Row 0 under back-pressure
        '{2'b10, 3'd4, 32'h12FF_FF80, 16'd20, 16'd6,  7'd0},   // Snow wrapping at 24 bits
        '{2'b10, 3'd2, 32'h0000_4000, 16'd9,  16'd4,  7'd40},  // Snow with back-pressure
        '{2'b01, 3'd4, 32'h0000_0000, 16'd8,  16'd8,  7'd25}   // Counter back from 0
    };

    logic                     CMD_CLK;
    logic                     reset;
    logic [1:0]               buttons;
    disp_cfg_t                disp_cfg;
    logic                     write_busy;
    logic                     write_req;
    logic [`DRAW_ADDR_W-1:0]  write_adr;
    logic [`DRAW_PIXEL_W-1:0] write_data;
    logic [`DRAW_PIXEL_W-1:0] rnd_out;

    logic [31:0] rng_state = 32'hd819;  // Busy pattern source
    logic [6:0]  busy_pct  = '0;
    logic        busy_next = 1'b0;
    logic [36:0] casr_m;                // Random generator model
    logic [42:0] lfsr_m;
    logic [31:0] rnd_m;
    logic        model_live = 1'b0;
    logic [31:0] rnd_hist[$];           // Model value of every cycle
    logic [`DRAW_ADDR_W-1:0]  adr_q[$]; // Collected writes
    logic [`DRAW_PIXEL_W-1:0] data_q[$];
    int          idle_cycles = 0;

    pattern_draw_top dut_i (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Counter pattern of pixel k since the press
    function automatic logic [31:0] counter_color(input int unsigned k);
        logic [31:0] hi;
        logic [31:0] mid;
        hi  = (k >> 13) & 32'h0000_00FF;   // Counter bits 20..13 in the top byte
        mid = (k >> 1) & 32'h0000_FFFF;    // Counter bits 16..1 below them
        return (hi << 24) | (mid << 8);
    endfunction

    // Byte address of raster position p
    function automatic logic [31:0] raster_addr(input stim_row_t r, input int unsigned p);
        logic [31:0] a;
        a = r.mem_addr + (p / 32'(r.width)) * 32'(r.width) + p % 32'(r.width);
        case (r.pixel_bytes)
            3'd2:    a = a << 1;
            3'd4:    a = a << 2;
            default: a = a;
        endcase
        return {8'h00, a[23:0]};                  // 24 bit memory port
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    // Whole frames in raster order with data from the counter or the model history
    task automatic check_frames(input stim_row_t r, input int start_j);
        int unsigned frame;
        int          j;
        int          last_j;
        frame  = r.width * r.height;
        last_j = start_j;
        check_val("write count mod frame", 32'd0, 32'(adr_q.size() % frame));
        for (int k = 0; k < adr_q.size(); k++) begin
            check_val("write_adr", raster_addr(r, k % frame), 32'(adr_q[k]));
            if (r.buttons[0]) begin
                check_val("write_data", counter_color(k), data_q[k]);
            end else begin
                j = last_j + 1;                   // Colors come in generator order
                while (j < rnd_hist.size() - 1 && rnd_hist[j] !== data_q[k]) j++;
                check_val("write_data", rnd_hist[j], data_q[k]);
                last_j = j;
            end
        end
    endtask

    initial begin
        CMD_CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CMD_CLK = ~CMD_CLK;
    end

    // *************************************************************************
    // Random generator model with rule 90/150 CASR and 43 bit LFSR
    // *************************************************************************
    always @(posedge CMD_CLK) begin
        logic [36:0] c;
        logic [42:0] l;
        c = casr_m;
        l = lfsr_m;
        if (reset) begin
            casr_m     = 37'h1_0000_0000;
            lfsr_m     = 43'h1_0000_0000;
            rnd_m      = '0;
            model_live = 1'b1;
        end else begin
            rnd_m = c[31:0] ^ l[31:0];            // Output of the old state
            for (int i = 0; i < 37; i++)
                casr_m[i] = c[(i + 36) % 37] ^ c[(i + 1) % 37] ^ (i == 27 ? c[i] : 1'b0);
            for (int i = 0; i < 43; i++)
                lfsr_m[i] = l[(i + 42) % 43] ^ ((i == 41 || i == 20 || i == 1) ? l[42] : 1'b0);
        end
    end

    // Memory port model drives busy on the falling edge and samples the settled port
    initial begin
        write_busy = 1'b0;
        forever begin
            @(negedge CMD_CLK);
            write_busy = busy_next;
            #SAMPLE_DLY;
            if (model_live) begin
                check_val("rnd_out", rnd_m, rnd_out);
                rnd_hist.push_back(rnd_m);
            end
            if (write_req === 1'b1) begin         // Transfer at the next rising edge
                adr_q.push_back(write_adr);
                data_q.push_back(write_data);
                idle_cycles = 0;
            end else begin
                idle_cycles++;
            end
            rng_state = xorshift32(rng_state);
            busy_next = (rng_state % 100) < busy_pct;
        end
    end

    // *************************************************************************
    // Main sequence
    // *************************************************************************
    initial begin
        int unsigned frame;
        int          waited;
        int          start_j;
        reset    = 1'b1;
        buttons  = 2'b11;                         // Both released
        disp_cfg = '0;
        repeat (2) @(negedge CMD_CLK);
        reset = 1'b0;
        foreach (ROWS[r]) begin
            frame = ROWS[r].width * ROWS[r].height;
            adr_q.delete();
            data_q.delete();
            start_j              = rnd_hist.size() - 1;
            disp_cfg.pixel_bytes = ROWS[r].pixel_bytes;
            disp_cfg.mem_addr    = ROWS[r].mem_addr;
            disp_cfg.width       = ROWS[r].width;
            disp_cfg.height      = ROWS[r].height;
            busy_pct             = ROWS[r].busy_pct;
            buttons              = ROWS[r].buttons;
            waited = 0;
            while (adr_q.size() < frame) begin    // Hold for one full frame
                @(negedge CMD_CLK);
                waited++;
                if (waited > 30 * frame + 200)
                    abort_run("Timeout waiting for a full frame of memory writes");
            end
            buttons = 2'b11;
            waited  = 0;
            while (idle_cycles < IDLE_WIN) begin  // Frame in progress ends and the port goes quiet
                @(negedge CMD_CLK);
                waited++;
                if (waited > 40 * frame + 400)
                    abort_run("Timeout, writes kept coming after the buttons were released");
            end
            check_frames(ROWS[r], start_j);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

/* sim/tb_pattern_draw_properties.sv */
`timescale 1ns/1ns
`include "draw_macros.svh"

// Memory port and FIFO rules of the write cache
module tb_pattern_draw_properties (
    input logic                                CMD_CLK,
    input logic                                reset,
    input logic                                write_busy,
    input logic                                write_req,
    input logic [`DRAW_ADDR_W-1:0]             write_adr,
    input logic [`DRAW_PIXEL_W-1:0]            write_data,
    input logic                                stage_full,
    input logic                                wr_push,
    input logic                                fifo_pop,
    input logic                                fifo_full,
    input logic [$clog2(`DRAW_FIFO_DEPTH)-1:0] wr_ptr,
    input logic [$clog2(`DRAW_FIFO_DEPTH)-1:0] rd_ptr
);

    // No transfer into a busy memory, the held entry stays in the stage
    busy_keeps_entry: assert property (@(posedge CMD_CLK) disable iff (reset)
        (stage_full && write_busy) |=> stage_full)
        else $error("Entry left the output stage while write_busy was high");

    // Blocked entry keeps address and data
    hold_blocked: assert property (@(posedge CMD_CLK) disable iff (reset)
        (stage_full && write_busy) |=> ($stable(write_adr) && $stable(write_data)))
        else $error("write_adr or write_data changed while blocked by write_busy");

    // Pixel strobe from the address pipe never meets a full RAM
    no_overflow: assert property (@(posedge CMD_CLK) disable iff (reset)
        !(wr_push && fifo_full))
        else $error("FIFO push while full");

    // Equal pointers mean empty unless the count says full
    no_underflow: assert property (@(posedge CMD_CLK) disable iff (reset)
        fifo_pop |-> (wr_ptr != rd_ptr || fifo_full))
        else $error("FIFO pop while empty");

    // Port quiet once reset has been seen
    req_low_in_reset: assert property (@(posedge CMD_CLK) reset |=> !write_req)
        else $error("write_req high during reset");

endmodule

bind write_cache tb_pattern_draw_properties props_i (
    .CMD_CLK    (CMD_CLK),
    .reset      (reset),
    .write_busy (write_busy),
    .write_req  (write_req),
    .write_adr  (write_adr),
    .write_data (write_data),
    .stage_full (stage_full),
    .wr_push    (wr_push),
    .fifo_pop   (fifo_pop),
    .fifo_full  (fifo_full),
    .wr_ptr     (wr_ptr),
    .rd_ptr     (rd_ptr)
);

/* design/pattern_draw_top.sv */
`timescale 1ns/1ns
`include "draw_macros.svh"

// Test pattern drawing into a memory mapped bitmap
module pattern_draw_top (
    input  logic                     CMD_CLK,
    input  logic                     reset,
    input  logic [1:0]               buttons,     // Active low
    input  draw_pkg::disp_cfg_t      disp_cfg,
    input  logic                     write_busy,
    output logic                     write_req,
    output logic [`DRAW_ADDR_W-1:0]  write_adr,
    output logic [`DRAW_PIXEL_W-1:0] write_data,
    output logic [`DRAW_PIXEL_W-1:0] rnd_out      // Random value for other users
);

    import draw_pkg::*;

    logic [`DRAW_PIXEL_W-1:0] rnd;
    pixel_t                   pix;         // Sequencer to address pipe
    mem_write_t               wr;          // Address pipe to cache
    logic                     wr_push;
    logic                     cache_busy;  // Back-pressure to the sequencer

    assign rnd_out = rnd;

    // *************************************************************************
    // Pattern source
    // *************************************************************************
    rnd_gen rnd_gen_i (
        .CMD_CLK (CMD_CLK),
        .reset   (reset),
        .rnd     (rnd)
    );

    pattern_sequencer pattern_sequencer_i (
        .CMD_CLK    (CMD_CLK),
        .reset      (reset),
        .buttons    (buttons),
        .disp_cfg   (disp_cfg),
        .rnd        (rnd),
        .cache_busy (cache_busy),
        .pix        (pix)
    );

    // *************************************************************************
    // Address generation and memory write port
    // *************************************************************************
    pixel_addr_pipe pixel_addr_pipe_i (
        .CMD_CLK  (CMD_CLK),
        .reset    (reset),
        .pix      (pix),
        .disp_cfg (disp_cfg),
        .wr       (wr),
        .wr_push  (wr_push)
    );

    write_cache write_cache_i (
        .CMD_CLK    (CMD_CLK),
        .reset      (reset),
        .wr         (wr),
        .wr_push    (wr_push),
        .write_busy (write_busy),
        .cache_busy (cache_busy),
        .write_req  (write_req),
        .write_adr  (write_adr),
        .write_data (write_data)
    );

endmodule

/* design/write_cache.sv */
`timescale 1ns/1ns
`include "draw_macros.svh"

// Show-ahead write FIFO with a registered output stage on the memory port
module write_cache (
    input  logic                      CMD_CLK,
    input  logic                      reset,
    input  draw_pkg::mem_write_t      wr,
    input  logic                      wr_push,
    input  logic                      write_busy,  // Memory cannot take a write
    output logic                      cache_busy,  // Almost full
    output logic                      write_req,
    output logic [`DRAW_ADDR_W-1:0]   write_adr,
    output logic [`DRAW_PIXEL_W-1:0]  write_data
);

    import draw_pkg::*;

    mem_write_t                          mem [`DRAW_FIFO_DEPTH];  // Cache RAM
    logic [$clog2(`DRAW_FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(`DRAW_FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(`DRAW_FIFO_DEPTH):0]   fifo_count;              // 0 to depth
    logic                                fifo_full;
    logic                                fifo_empty;
    logic                                fifo_push;
    logic                                fifo_pop;
    logic                                stage_full;  // Output stage holds an entry
    mem_write_t                          stage_q;

    // *************************************************************************
    // FIFO flags and strobes
    // *************************************************************************
    assign fifo_full  = fifo_count == `DRAW_FIFO_DEPTH;
    assign fifo_empty = fifo_count == 0;
    assign cache_busy = fifo_count >= `DRAW_FIFO_AFULL;

    assign fifo_push = wr_push && !fifo_full;  // Overflow protection

    // Refill the stage when it is empty or its entry leaves this cycle
    assign fifo_pop  = !fifo_empty && (!stage_full || !write_busy);

    // Transfer on every cycle the stage is loaded and memory is free
    assign write_req = stage_full && !write_busy;

    // RAM write side
    always_ff @(posedge CMD_CLK) begin
        if (fifo_push) begin
            mem[wr_ptr] <= wr;
        end
    end

    // Pointers and fill count
    always_ff @(posedge CMD_CLK) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (fifo_push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
            if (fifo_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({fifo_push, fifo_pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;   // Both or neither
            endcase
        end
    end

    // *************************************************************************
    // Output stage
    // *************************************************************************
    always_ff @(posedge CMD_CLK) begin
        if (reset) begin
            stage_full <= 1'b0;
        end else if (fifo_pop) begin
            stage_full <= 1'b1;
        end else if (write_req) begin
            stage_full <= 1'b0;                      // Drained, nothing behind it
        end
    end

    // Show-ahead read, entry held while memory is busy
    always_ff @(posedge CMD_CLK) begin
        if (fifo_pop) begin
            stage_q <= mem[rd_ptr];
        end
    end

    assign write_adr  = stage_q.addr;
    assign write_data = stage_q.data;

endmodule

/* design/pixel_addr_pipe.sv */
`timescale 1ns/1ns
`include "draw_macros.svh"

// Pixel coordinates to byte address, two register stages
module pixel_addr_pipe (
    input  logic                CMD_CLK,
    input  logic                reset,
    input  draw_pkg::pixel_t    pix,
    input  draw_pkg::disp_cfg_t disp_cfg,
    output draw_pkg::mem_write_t wr,
    output logic                wr_push     // Write strobe into the cache
);

    import draw_pkg::*;

    logic [1:0]               byte_shift;  // log2 of bytes per pixel
    logic                     valid_s1;
    logic [`DRAW_ADDR_W-1:0]  row_base_s1; // Address of pixel 0 of the row
    logic [`DRAW_COORD_W-1:0] x_s1;
    logic [`DRAW_PIXEL_W-1:0] color_s1;

    // Bytes per pixel to address shift
    always_comb begin
        case (disp_cfg.pixel_bytes)
            3'd2:    byte_shift = 2'd1;
            3'd4:    byte_shift = 2'd2;
            default: byte_shift = 2'd0;    // 8 bit pixels
        endcase
    end

    // *************************************************************************
    // Stage 1, row base from y
    // *************************************************************************
    always_ff @(posedge CMD_CLK) begin
        if (reset) begin
            valid_s1 <= 1'b0;
        end else begin
            valid_s1 <= pix.valid;
        end
        // Low address bits only, upper bits fall off later anyway
        row_base_s1 <= `DRAW_ADDR_W'(disp_cfg.mem_addr + 32'(pix.y) * 32'(disp_cfg.width));
        x_s1        <= pix.x;
        color_s1    <= pix.color;             // Color rides along
    end

    // *************************************************************************
    // Stage 2, add x and scale to bytes
    // *************************************************************************
    always_ff @(posedge CMD_CLK) begin
        if (reset) begin
            wr_push <= 1'b0;
        end else begin
            wr_push <= valid_s1;
        end
        wr.addr <= (row_base_s1 + `DRAW_ADDR_W'(x_s1)) << byte_shift;
        wr.data <= color_s1;
    end

endmodule

/* design/pattern_sequencer.sv */
`timescale 1ns/1ns
`include "draw_macros.svh"

// Button driven fill of the whole bitmap in raster order
module pattern_sequencer (
    input  logic                     CMD_CLK,
    input  logic                     reset,
    input  logic [1:0]               buttons,     // Active low
    input  draw_pkg::disp_cfg_t      disp_cfg,
    input  logic [`DRAW_PIXEL_W-1:0] rnd,
    input  logic                     cache_busy,  // Write cache almost full
    output draw_pkg::pixel_t         pix
);

    import draw_pkg::*;

    seq_state_t              state;
    fill_mode_t              mode;        // Sampled at each frame start
    logic [1:0]              buttons_l;   // Latched buttons
    logic [`DRAW_COORD_W-1:0] x;          // Raster position of the next pixel
    logic [`DRAW_COORD_W-1:0] y;
    logic [20:0]             counter;     // Pixels drawn since idle
    logic                    x_last;
    logic                    y_last;
    logic [`DRAW_PIXEL_W-1:0] count_color;

    // *************************************************************************
    // Raster limits and pattern color
    // *************************************************************************

    // Coordinates are positive, compare as signed against the geometry
    assign x_last = $signed({2'b00, x}) >= disp_cfg.width - 16'sd1;
    assign y_last = $signed({2'b00, y}) >= disp_cfg.height - 16'sd1;

    // Two overlapping counter slices, low byte black
    assign count_color = {counter[20:13], counter[16:1], 8'h00};

    // *************************************************************************
    // Fill FSM
    // *************************************************************************
    always_ff @(posedge CMD_CLK) begin
        if (reset) begin
            state     <= SEQ_IDLE;
            buttons_l <= 2'b11;        // Released
            counter   <= '0;
            pix.valid <= 1'b0;
        end else begin
            buttons_l <= buttons;
            pix.valid <= 1'b0;         // No pixel unless one is drawn below

            case (state)
                SEQ_IDLE: begin
                    counter <= '0;
                    if (buttons_l != 2'b11) begin
                        state <= SEQ_FRAME_START;  // Any button pressed
                    end
                end

                SEQ_FRAME_START: begin
                    x    <= '0;
                    y    <= '0;
                    mode <= buttons_l[0] ? FILL_COUNTER : FILL_RANDOM;
                    if (buttons_l == 2'b11) begin
                        state <= SEQ_IDLE;         // Both released
                    end else begin
                        state <= SEQ_FILL;         // Draw another frame
                    end
                end

                SEQ_FILL: begin
                    if (!cache_busy) begin         // Hold while the cache fills up
                        pix.valid <= 1'b1;
                        pix.x     <= x;
                        pix.y     <= y;
                        pix.color <= (mode == FILL_COUNTER) ? count_color : rnd;
                        counter   <= counter + 1'b1;

                        if (!x_last) begin
                            x <= x + 1'b1;
                        end else begin
                            x <= '0;               // End of row
                            if (!y_last) begin
                                y <= y + 1'b1;
                            end else begin
                                y     <= '0;
                                state <= SEQ_FRAME_START;  // Frame done, recheck buttons
                            end
                        end
                    end
                end

                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

/* design/rnd_gen.sv */
`timescale 1ns/1ns
`include "draw_macros.svh"

// Combined cellular automaton and LFSR random source, one value per clock
module rnd_gen (
    input  logic                     CMD_CLK,
    input  logic                     reset,
    output logic [`DRAW_PIXEL_W-1:0] rnd
);

    logic [36:0] casr;       // Rule 90/150 cellular automaton
    logic [42:0] lfsr;       // Rotating LFSR
    logic [36:0] casr_next;
    logic [42:0] lfsr_next;

    // *************************************************************************
    // Next state of both registers
    // *************************************************************************

    // Rule 90 on every cell from both neighbours, cell 27 adds itself for rule 150
    assign casr_next = {casr[35:0], casr[36]}
                     ^ {casr[0], casr[36:1]}
                     ^ (37'(casr[27]) << 27);

    // Rotate left, feed the top bit into taps 41, 20 and 1
    assign lfsr_next = {lfsr[41:0], lfsr[42]}
                     ^ (43'(lfsr[42]) << 41)
                     ^ (43'(lfsr[42]) << 20)
                     ^ (43'(lfsr[42]) << 1);

    always_ff @(posedge CMD_CLK) begin
        if (reset) begin
            casr <= 37'h1_0000_0000;  // Start point 2^32, never all zero
            lfsr <= 43'h1_0000_0000;
            rnd  <= '0;
        end else begin
            casr <= casr_next;
            lfsr <= lfsr_next;
            // Output mixes the current state, lags the registers by one step
            rnd  <= lfsr[31:0] ^ casr[31:0];
        end
    end

endmodule

/* design/draw_pkg.sv */
`include "draw_macros.svh"

package draw_pkg;

    // *************************************************************************
    // Bitmap geometry, static while a fill runs
    // *************************************************************************
    typedef struct packed {
        logic [2:0]         pixel_bytes;  // 4, 2 or 1 bytes per pixel
        logic [31:0]        mem_addr;     // Pixel address of position 0x0
        logic signed [15:0] width;        // Bitmap width in pixels
        logic signed [15:0] height;       // Bitmap height in pixels
    } disp_cfg_t;

    // One drawn pixel
    typedef struct packed {
        logic                     valid;
        logic [`DRAW_COORD_W-1:0] x;
        logic [`DRAW_COORD_W-1:0] y;
        logic [`DRAW_PIXEL_W-1:0] color;
    } pixel_t;

    // One memory write, as it sits in the cache
    typedef struct packed {
        logic [`DRAW_ADDR_W-1:0]  addr;   // Byte address
        logic [`DRAW_PIXEL_W-1:0] data;
    } mem_write_t;

    // Fill sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE,         // Waiting for a button
        SEQ_FRAME_START,  // Rewind to 0x0, sample the mode
        SEQ_FILL          // Raster walk over the bitmap
    } seq_state_t;

    // Fill opcode
    typedef enum logic {
        FILL_RANDOM  = 1'b0,  // Snow from the random generator
        FILL_COUNTER = 1'b1   // Pattern from the pixel counter
    } fill_mode_t;

endpackage

/* design/draw_macros.svh */
`ifndef DRAW_MACROS_SVH
`define DRAW_MACROS_SVH

// *************************************************************************
// Project wide widths
// *************************************************************************

// Memory byte address on the write port
`define DRAW_ADDR_W 24

// Pixel color and write data
`define DRAW_PIXEL_W 32

// Bitmap x and y coordinates
`define DRAW_COORD_W 14

// *************************************************************************
// Write cache sizing
// *************************************************************************

`define DRAW_FIFO_DEPTH 64  // Entries in the write cache RAM

// Fill count that raises busy, leaves room for pixels still in the pipe
`define DRAW_FIFO_AFULL 48

`endif
